// File: sources.f
+incdir+.
dma_pkg.sv
rd_req_capture.sv
rd_burst_sequencer.sv
ar_channel.sv
r_channel.sv
otl_axi_dma_rd.sv
tb_otl_axi_dma_rd.sv

// File: run.sh
#!/bin/sh
# build the read DMA testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module tb_otl_axi_dma_rd -f sources.f -o sim_tb

./obj_dir/sim_tb | tee sim.log

grep -q "Verification passed" sim.log

// File: tb_otl_axi_dma_rd.sv
// testbench for the AXI read DMA engine: AXI read slave model, scoreboard and assertions
`timescale 1ns/1ps
`include "dma_cfg.svh"

module tb_otl_axi_dma_rd;

   import dma_pkg::*;

   // slave data is the beat address scrambled by this key
   localparam data_t DATA_KEY = 32'h5a3c_96e1;
   localparam int WAIT_LIMIT = 2000;

   logic       m_axi_aclk = 1'b0;
   logic       m_axi_aresetn = 1'b0;
   logic       m_axi_arready = 1'b0;
   logic       m_axi_rvalid = 1'b0;
   data_t      m_axi_rdata = '0;
   logic       m_axi_rlast = 1'b0;
   id_t        m_axi_rid = '0;
   logic [1:0] m_axi_rresp = 2'b00;
   logic       m_axi_ruser = 1'b0;
   addr_t      otl_rdaddr = '0;
   len_t       otl_rdlen = '0;
   logic       otl_rdready = 1'b0;

   id_t        m_axi_arid;
   addr_t      m_axi_araddr;
   axlen_t     m_axi_arlen;
   logic [2:0] m_axi_arsize;
   logic [1:0] m_axi_arburst;
   logic       m_axi_arlock;
   logic [3:0] m_axi_arcache;
   logic [2:0] m_axi_arprot;
   logic [3:0] m_axi_arqos;
   logic       m_axi_aruser;
   logic       m_axi_arvalid;
   logic       m_axi_rready;
   data_t      otl_rddata;
   logic       otl_rdvalid;
   logic       otl_rdbusy;

   // scoreboard queues filled when a transfer is requested
   addr_t  exp_ar_addr[$];
   axlen_t exp_ar_len[$];
   data_t  exp_data[$];

   int     errors = 0;
   int     timeouts = 0;
   int     checks = 0;
   int     ar_seen = 0;
   int     strobes = 0;
   integer seed = 35;
   logic   busy_q = 1'b0;
   // slave side view of the burst in flight
   addr_t  r_addr = '0;
   int     r_left = 0;

   always #10 m_axi_aclk = ~m_axi_aclk;

   otl_axi_dma_rd i_otl_axi_dma_rd (.*);

   // ********************
   // helpers
   // ********************

   task automatic expect_equal(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
      checks++;
      assert (got === exp)
      else
      begin
         errors++;
         $display("[FAIL] %s: got %h, expected %h", name, got, exp);
      end
   endtask

   // bursts and beats as the splitting rule gives them
   task automatic predict(input addr_t base, input len_t len);
      len_t  left;
      len_t  take;
      addr_t addr;
      int    i;
      left = len;
      addr = base;
      while (left != 0)
      begin
         take = (left > len_t'(`DMA_BURST_LEN)) ? len_t'(`DMA_BURST_LEN) : left;
         exp_ar_addr.push_back(addr);
         exp_ar_len.push_back(axlen_t'(take - 1));
         addr = addr + addr_t'(`DMA_BURST_LEN * BEAT_BYTES);
         left = left - take;
      end
      for (i = 0; i < int'(len); i++)
         exp_data.push_back((base + addr_t'(i * BEAT_BYTES)) ^ DATA_KEY);
   endtask

   task automatic pulse_request(input addr_t addr, input len_t len);
      @(posedge m_axi_aclk);
      otl_rdaddr  <= addr;
      otl_rdlen   <= len;
      otl_rdready <= 1'b1;
      repeat (2) @(posedge m_axi_aclk);
      otl_rdready <= 1'b0;
      @(posedge m_axi_aclk);
   endtask

   task automatic end_simulation;
      $display("checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
      if (errors == 0 && timeouts == 0)
         $display("Verification passed");
      else
         $display("Verification failed");
      $finish;
   endtask

   task automatic wait_busy(input logic level);
      int cnt;
      cnt = 0;
      while (otl_rdbusy !== level && cnt < WAIT_LIMIT)
      begin
         @(posedge m_axi_aclk);
         cnt++;
      end
      if (otl_rdbusy !== level)
      begin
         timeouts++;
         $display("timeout: otl_rdbusy did not reach %0b within %0d cycles", level, WAIT_LIMIT);
      end
   endtask

   // extra_edge raises otl_rdready again in the middle of the transfer
   task automatic run_transfer(input addr_t base, input len_t len, input logic extra_edge);
      int ar_before;
      int strobes_before;
      ar_before = ar_seen;
      strobes_before = strobes;
      predict(base, len);
      pulse_request(base, len);
      wait_busy(1'b1);
      if (extra_edge)
      begin
         pulse_request(base + 32'h0000_1000, 32'd7);
         expect_equal("otl_rdbusy during extra request", 32'(otl_rdbusy), 32'd1);
      end
      wait_busy(1'b0);
      @(posedge m_axi_aclk);
      expect_equal("AR count", 32'(ar_seen - ar_before),
                   32'((int'(len) + `DMA_BURST_LEN - 1) / `DMA_BURST_LEN));
      expect_equal("otl_rdvalid strobe count", 32'(strobes - strobes_before), len);
   endtask

   task automatic zero_length_request(input addr_t addr);
      int ar_before;
      ar_before = ar_seen;
      pulse_request(addr, '0);
      repeat (20)
      begin
         @(posedge m_axi_aclk);
         expect_equal("otl_rdbusy", 32'(otl_rdbusy), 32'd0);
      end
      expect_equal("AR count after zero length request", 32'(ar_seen - ar_before), 32'd0);
   endtask

   // ********************
   // AXI read slave model
   // ********************

   always @(posedge m_axi_aclk)
   begin
      if (!m_axi_aresetn)
      begin
         m_axi_arready <= 1'b0;
         m_axi_rvalid  <= 1'b0;
         m_axi_rlast   <= 1'b0;
         r_left = 0;
      end
      else
      begin
         // new address only once the previous burst has fully returned
         assert (!(m_axi_arvalid && (m_axi_rready || r_left != 0)))
         else
         begin
            errors++;
            $display("m_axi_arvalid was high while a burst was still outstanding");
         end
         if (m_axi_arvalid && m_axi_arready)
         begin
            r_addr = m_axi_araddr;
            r_left = int'(m_axi_arlen) + 1;
         end
         if (m_axi_rvalid && m_axi_rready)
         begin
            r_addr = r_addr + addr_t'(BEAT_BYTES);
            r_left = r_left - 1;
         end
         m_axi_arready <= (($random(seed) & 3) != 0);
         // a presented beat stays until it is taken
         if (!(m_axi_rvalid && !m_axi_rready))
         begin
            m_axi_rvalid <= (r_left != 0) && (($random(seed) & 3) != 3);
            m_axi_rdata  <= r_addr ^ DATA_KEY;
            m_axi_rlast  <= (r_left == 1);
         end
      end
   end

   // ********************
   // checking
   // ********************

   assert property (@(posedge m_axi_aclk) disable iff (!m_axi_aresetn)
      (m_axi_arvalid && !m_axi_arready) |=>
      (m_axi_arvalid && $stable(m_axi_araddr) && $stable(m_axi_arlen)))
   else
   begin
      errors++;
      $display("[FAIL] m_axi_araddr/m_axi_arlen changed under stall: araddr=%h arlen=%h",
               m_axi_araddr, m_axi_arlen);
   end

   assert property (@(posedge m_axi_aclk) disable iff (!m_axi_aresetn)
      (m_axi_rvalid && m_axi_rready) |=> otl_rdvalid)
   else
   begin
      errors++;
      $display("[FAIL] otl_rdvalid: got %h, expected %h", otl_rdvalid, 1'b1);
   end

   always @(posedge m_axi_aclk)
   begin
      if (m_axi_aresetn && m_axi_arvalid && m_axi_arready)
      begin
         ar_seen++;
         assert (exp_ar_addr.size() != 0)
         else
         begin
            errors++;
            $display("AR handshake at %h with no burst predicted", m_axi_araddr);
         end
         if (exp_ar_addr.size() != 0)
         begin
            expect_equal("m_axi_araddr", m_axi_araddr, exp_ar_addr.pop_front());
            expect_equal("m_axi_arlen", 32'(m_axi_arlen), 32'(exp_ar_len.pop_front()));
            expect_equal("m_axi_arsize", 32'(m_axi_arsize), 32'(AR_SIZE));
            expect_equal("m_axi_arburst", 32'(m_axi_arburst), 32'(AR_BURST_INCR));
         end
         // fixed fields of the address channel
         expect_equal("m_axi_arid", 32'(m_axi_arid), 32'(AR_ID));
         expect_equal("m_axi_arlock", 32'(m_axi_arlock), 32'(AR_LOCK));
         expect_equal("m_axi_arcache", 32'(m_axi_arcache), 32'(AR_CACHE));
         expect_equal("m_axi_arprot", 32'(m_axi_arprot), 32'(AR_PROT));
         expect_equal("m_axi_arqos", 32'(m_axi_arqos), 32'(AR_QOS));
         expect_equal("m_axi_aruser", 32'(m_axi_aruser), 32'(AR_USER));
      end
      if (m_axi_aresetn && otl_rdvalid)
      begin
         strobes++;
         assert (exp_data.size() != 0)
         else
         begin
            errors++;
            $display("otl_rdvalid strobe with no beat left to expect");
         end
         if (exp_data.size() != 0)
            expect_equal("otl_rddata", otl_rddata, exp_data.pop_front());
      end
      // the last strobe is seen no later than the falling busy
      if (busy_q && !otl_rdbusy)
      begin
         assert (exp_data.size() == 0 && exp_ar_addr.size() == 0)
         else
         begin
            errors++;
            $display("otl_rdbusy fell with %0d beats still expected", exp_data.size());
         end
      end
      busy_q <= otl_rdbusy;
   end

   // ********************
   // stimulus
   // ********************

   initial
   begin
      repeat (5) @(posedge m_axi_aclk);
      m_axi_aresetn <= 1'b1;
      @(posedge m_axi_aclk);
      expect_equal("m_axi_arvalid", 32'(m_axi_arvalid), 32'd0);
      expect_equal("m_axi_rready", 32'(m_axi_rready), 32'd0);
      expect_equal("otl_rdvalid", 32'(otl_rdvalid), 32'd0);
      expect_equal("otl_rdbusy", 32'(otl_rdbusy), 32'd0);
      run_transfer(32'h1000_0000, 32'd5, 1'b0);
      run_transfer(32'h2000_0040, 32'd37, 1'b0);
      zero_length_request(32'h3000_0000);
      run_transfer(32'h4000_0100, 32'd37, 1'b1);
      run_transfer(32'h5000_0000, 32'd16, 1'b0);
      end_simulation();
   end

endmodule

// File: otl_axi_dma_rd.sv
// top level of the AXI read DMA engine: submodule wiring and fixed AR fields
`timescale 1ns/1ps

module otl_axi_dma_rd
(
   input  logic            m_axi_aclk,
   input  logic            m_axi_aresetn,

   // read address channel
   output dma_pkg::id_t    m_axi_arid,
   output dma_pkg::addr_t  m_axi_araddr,
   output dma_pkg::axlen_t m_axi_arlen,
   output logic [2:0]      m_axi_arsize,
   output logic [1:0]      m_axi_arburst,
   output logic            m_axi_arlock,
   output logic [3:0]      m_axi_arcache,
   output logic [2:0]      m_axi_arprot,
   output logic [3:0]      m_axi_arqos,
   output logic            m_axi_aruser,
   output logic            m_axi_arvalid,
   input  logic            m_axi_arready,

   // read data channel, response and id are not checked
   input  dma_pkg::id_t    m_axi_rid,
   input  dma_pkg::data_t  m_axi_rdata,
   input  logic [1:0]      m_axi_rresp,
   input  logic            m_axi_rlast,
   input  logic            m_axi_ruser,
   input  logic            m_axi_rvalid,
   output logic            m_axi_rready,

   // DMA read port
   input  dma_pkg::addr_t  otl_rdaddr,
   input  dma_pkg::len_t   otl_rdlen,
   input  logic            otl_rdready,
   output dma_pkg::data_t  otl_rddata,
   output logic            otl_rdvalid,
   output logic            otl_rdbusy
);

   import dma_pkg::*;

   logic   rd_start;
   addr_t  req_addr;
   len_t   req_len;
   logic   burst_req;
   addr_t  burst_addr;
   axlen_t burst_axlen;
   logic   ar_done;
   logic   burst_end;

   // ********************
   // constant AR fields
   // ********************

   assign m_axi_arid    = AR_ID;
   assign m_axi_arsize  = AR_SIZE;
   assign m_axi_arburst = AR_BURST_INCR;
   assign m_axi_arlock  = AR_LOCK;
   assign m_axi_arcache = AR_CACHE;
   assign m_axi_arprot  = AR_PROT;
   assign m_axi_arqos   = AR_QOS;
   assign m_axi_aruser  = AR_USER;

   // ********************
   // datapath
   // ********************

   rd_req_capture i_rd_req_capture
   (
      .m_axi_aclk    (m_axi_aclk),
      .m_axi_aresetn (m_axi_aresetn),
      .otl_rdready   (otl_rdready),
      .otl_rdaddr    (otl_rdaddr),
      .otl_rdlen     (otl_rdlen),
      .rd_start      (rd_start),
      .req_addr      (req_addr),
      .req_len       (req_len)
   );

   rd_burst_sequencer i_rd_burst_sequencer
   (
      .m_axi_aclk    (m_axi_aclk),
      .m_axi_aresetn (m_axi_aresetn),
      .rd_start      (rd_start),
      .req_addr      (req_addr),
      .req_len       (req_len),
      .burst_end     (burst_end),
      .burst_req     (burst_req),
      .burst_addr    (burst_addr),
      .burst_axlen   (burst_axlen),
      .otl_rdbusy    (otl_rdbusy)
   );

   ar_channel i_ar_channel
   (
      .m_axi_aclk    (m_axi_aclk),
      .m_axi_aresetn (m_axi_aresetn),
      .burst_req     (burst_req),
      .burst_addr    (burst_addr),
      .burst_axlen   (burst_axlen),
      .m_axi_arready (m_axi_arready),
      .m_axi_arvalid (m_axi_arvalid),
      .m_axi_araddr  (m_axi_araddr),
      .m_axi_arlen   (m_axi_arlen),
      .ar_done       (ar_done)
   );

   r_channel i_r_channel
   (
      .m_axi_aclk    (m_axi_aclk),
      .m_axi_aresetn (m_axi_aresetn),
      .ar_done       (ar_done),
      .m_axi_rvalid  (m_axi_rvalid),
      .m_axi_rdata   (m_axi_rdata),
      .m_axi_rlast   (m_axi_rlast),
      .m_axi_rready  (m_axi_rready),
      .otl_rddata    (otl_rddata),
      .otl_rdvalid   (otl_rdvalid),
      .burst_end     (burst_end)
   );

endmodule

// File: r_channel.sv
// AXI read data channel: rready control and forwarding of beats to the DMA port
`timescale 1ns/1ps

module r_channel
(
   input  logic           m_axi_aclk,
   input  logic           m_axi_aresetn,

   // address accepted for the outstanding burst
   input  logic           ar_done,

   // AXI R channel
   input  logic           m_axi_rvalid,
   input  dma_pkg::data_t m_axi_rdata,
   input  logic           m_axi_rlast,
   output logic           m_axi_rready,

   // DMA side strobe
   output dma_pkg::data_t otl_rddata,
   output logic           otl_rdvalid,

   // last beat of the burst accepted
   output logic           burst_end
);

   logic r_ack;

   // ********************
   // handshake
   // ********************

   assign r_ack     = m_axi_rvalid && m_axi_rready;
   assign burst_end = r_ack && m_axi_rlast;

   // open for the outstanding burst, close after its rlast beat
   always_ff @(posedge m_axi_aclk)
   begin
      if (!m_axi_aresetn)
      begin
         m_axi_rready <= 1'b0;
      end
      else if (ar_done)
      begin
         m_axi_rready <= 1'b1;
      end
      else if (burst_end)
      begin
         m_axi_rready <= 1'b0;
      end
   end

   // ********************
   // DMA output
   // ********************

   // one strobe per accepted beat, no stall possible downstream
   always_ff @(posedge m_axi_aclk)
   begin
      if (!m_axi_aresetn)
      begin
         otl_rdvalid <= 1'b0;
      end
      else
      begin
         otl_rdvalid <= r_ack;
      end
   end

   always_ff @(posedge m_axi_aclk)
   begin
      if (r_ack)
      begin
         otl_rddata <= m_axi_rdata;
      end
   end

endmodule

// File: ar_channel.sv
// AXI read address channel driver with hold under arready back-pressure
`timescale 1ns/1ps

module ar_channel
(
   input  logic            m_axi_aclk,
   input  logic            m_axi_aresetn,

   // burst request from the sequencer
   input  logic            burst_req,
   input  dma_pkg::addr_t  burst_addr,
   input  dma_pkg::axlen_t burst_axlen,

   // AXI AR handshake and payload
   input  logic            m_axi_arready,
   output logic            m_axi_arvalid,
   output dma_pkg::addr_t  m_axi_araddr,
   output dma_pkg::axlen_t m_axi_arlen,

   // address accepted, towards the R channel
   output logic            ar_done
);

   // ********************
   // handshake
   // ********************

   assign ar_done = m_axi_arvalid && m_axi_arready;

   // one burst outstanding, so a request never meets a pending AR
   always_ff @(posedge m_axi_aclk)
   begin
      if (!m_axi_aresetn)
      begin
         m_axi_arvalid <= 1'b0;
      end
      else if (burst_req)
      begin
         m_axi_arvalid <= 1'b1;
      end
      else if (ar_done)
      begin
         m_axi_arvalid <= 1'b0;
      end
   end

   // ********************
   // address and length
   // ********************

   // loaded only on a new request, stable while arvalid waits
   always_ff @(posedge m_axi_aclk)
   begin
      if (burst_req)
      begin
         m_axi_araddr <= burst_addr;
         m_axi_arlen  <= burst_axlen;
      end
   end

endmodule

// File: rd_burst_sequencer.sv
// burst sequencer: splits a read transfer into AXI bursts, tracks beats and busy
`timescale 1ns/1ps

module rd_burst_sequencer
(
   input  logic            m_axi_aclk,
   input  logic            m_axi_aresetn,

   // captured request
   input  logic            rd_start,
   input  dma_pkg::addr_t  req_addr,
   input  dma_pkg::len_t   req_len,

   // end of the outstanding burst, from the R channel
   input  logic            burst_end,

   // towards the AR channel
   output logic            burst_req,
   output dma_pkg::addr_t  burst_addr,
   output dma_pkg::axlen_t burst_axlen,

   output logic            otl_rdbusy
);

   import dma_pkg::*;

   typedef enum logic
   {
      ST_IDLE,
      ST_ACTIVE
   } state_t;

   state_t state;
   // beats not yet requested on AR
   len_t   beats_left;
   len_t   beats_src;
   len_t   beats_take;
   logic   launch_first;
   logic   launch_next;
   logic   finish;

   // ********************
   // burst sizing
   // ********************

   // first burst sizes from the request, later ones from what is left
   always_comb
   begin
      beats_src  = (state == ST_IDLE) ? req_len : beats_left;
      beats_take = (beats_src > BURST_LEN) ? BURST_LEN : beats_src;
   end

   // busy edges and zero length requests are dropped here
   assign launch_first = (state == ST_IDLE) && rd_start && (req_len != '0);
   assign launch_next  = (state == ST_ACTIVE) && burst_end && (beats_left != '0);
   assign finish       = (state == ST_ACTIVE) && burst_end && (beats_left == '0);

   // ********************
   // control FSM
   // ********************

   always_ff @(posedge m_axi_aclk)
   begin
      if (!m_axi_aresetn)
      begin
         state      <= ST_IDLE;
         burst_req  <= 1'b0;
         beats_left <= '0;
      end
      else
      begin
         burst_req <= launch_first || launch_next;
         if (launch_first || launch_next)
         begin
            beats_left <= beats_src - beats_take;
         end
         if (launch_first)
         begin
            state <= ST_ACTIVE;
         end
         else if (finish)
         begin
            state <= ST_IDLE;
         end
      end
   end

   // ********************
   // burst address and length
   // ********************

   always_ff @(posedge m_axi_aclk)
   begin
      if (launch_first)
      begin
         burst_addr <= req_addr;
      end
      else if (launch_next)
      begin
         // every burst but the last one is full
         burst_addr <= burst_addr + BURST_BYTES;
      end
      if (launch_first || launch_next)
      begin
         burst_axlen <= axlen_t'(beats_take - len_t'(1));
      end
   end

   assign otl_rdbusy = (state == ST_ACTIVE);

endmodule

// File: rd_req_capture.sv
// request capture: otl_rdready edge detection and address/length latch
`timescale 1ns/1ps

module rd_req_capture
(
   input  logic           m_axi_aclk,
   input  logic           m_axi_aresetn,

   // DMA side request
   input  logic           otl_rdready,
   input  dma_pkg::addr_t otl_rdaddr,
   input  dma_pkg::len_t  otl_rdlen,

   // towards the burst sequencer
   output logic           rd_start,
   output dma_pkg::addr_t req_addr,
   output dma_pkg::len_t  req_len
);

   // two delay stages on the request level
   logic rdready_d;
   logic rdready_dd;

   // ********************
   // edge detection
   // ********************

   always_ff @(posedge m_axi_aclk)
   begin
      if (!m_axi_aresetn)
      begin
         rdready_d  <= 1'b0;
         rdready_dd <= 1'b0;
      end
      else
      begin
         rdready_d  <= otl_rdready;
         rdready_dd <= rdready_d;
      end
   end

   // high for one cycle after the first high sample
   assign rd_start = rdready_d && !rdready_dd;

   // ********************
   // request latch
   // ********************

   // taken together with the first high sample, so the
   // values line up with rd_start
   always_ff @(posedge m_axi_aclk)
   begin
      if (otl_rdready && !rdready_d)
      begin
         req_addr <= otl_rdaddr;
         req_len  <= otl_rdlen;
      end
   end

endmodule

// File: dma_pkg.sv
// shared types and fixed AXI read address field constants for the read DMA engine
`include "dma_cfg.svh"

package dma_pkg;

   // ********************
   // types
   // ********************

   typedef logic [`DMA_ADDR_WIDTH-1:0] addr_t;
   typedef logic [`DMA_DATA_WIDTH-1:0] data_t;
   typedef logic [`DMA_LEN_WIDTH-1:0]  len_t;
   typedef logic [7:0]                 axlen_t;
   typedef logic [`DMA_ID_WIDTH-1:0]   id_t;

   // ********************
   // derived sizes
   // ********************

   localparam int unsigned BEAT_BYTES = `DMA_DATA_WIDTH / 8;
   // address step of one full burst
   localparam addr_t BURST_BYTES = addr_t'(`DMA_BURST_LEN * BEAT_BYTES);
   localparam len_t BURST_LEN = len_t'(`DMA_BURST_LEN);

   // ********************
   // fixed AR fields
   // ********************

   localparam logic [2:0] AR_SIZE = 3'($clog2(BEAT_BYTES));
   localparam logic [1:0] AR_BURST_INCR = 2'b01;
   // normal non-cacheable, modifiable
   localparam logic [3:0] AR_CACHE = 4'b0010;
   localparam id_t AR_ID = '0;
   localparam logic AR_LOCK = 1'b0;
   localparam logic [2:0] AR_PROT = 3'h0;
   localparam logic [3:0] AR_QOS = 4'h0;
   localparam logic AR_USER = 1'b1;

endpackage

// File: dma_cfg.svh
// configuration macros for the AXI read DMA engine: burst length and bus widths
`ifndef DMA_CFG_SVH
`define DMA_CFG_SVH

// ********************
// burst shape
// ********************

// upper bound on beats in one AXI burst
`define DMA_BURST_LEN 16

// ********************
// bus widths
// ********************

// one data beat
`define DMA_DATA_WIDTH 32

// byte address on the AXI side and the DMA side
`define DMA_ADDR_WIDTH 32

// AXI transaction id
`define DMA_ID_WIDTH 12

// transfer length, counted in beats
`define DMA_LEN_WIDTH 32

`endif
